/* build.f */
+incdir+.
lsu_pkg.sv
axi_lite_if.sv
lsu_align.sv
lsu_ctrl.sv
axi_sram.sv
lsu_top.sv
tb_lsu.sv

/* Makefile */
TOP = tb_lsu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module lsu_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_lsu.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module tb_lsu
	import lsu_pkg::*;
();

	localparam int unsigned SEED = 32'h0c71_b961;
	localparam int TIMEOUT = 100;
	localparam int RESET_CYCLES = 10;
	localparam int WIN_BYTES = `LSU_SRAM_WORDS * 4;

	logic clock, rstn;
	logic exu_valid_i, exu_ready_o;
	mem_op_e exu_op_i;
	addr_t exu_addr_i;
	word_t exu_wdata_i;
	reg_idx_t exu_rd_i;
	logic wbu_valid_o, wbu_ready_i;
	reg_idx_t wbu_rd_o;
	word_t wbu_data_o;
	logic wbu_err_o;

	// byte image of the sram window
	logic [7:0] ref_mem [WIN_BYTES];
	// expected results with the oldest first
	reg_idx_t exp_rd_q[$];
	word_t exp_data_q[$];
	logic exp_err_q[$];
	reg_idx_t exp_rd;
	word_t exp_data;
	logic exp_err;
	// set from acceptance until the result is taken
	logic in_flight;
	int requests, results;
	int err_main, err_mon, err_hold, err_busy;

	lsu_top uut (
		.clock(clock),
		.rstn(rstn),
		.exu_valid_i(exu_valid_i),
		.exu_ready_o(exu_ready_o),
		.exu_op_i(exu_op_i),
		.exu_addr_i(exu_addr_i),
		.exu_wdata_i(exu_wdata_i),
		.exu_rd_i(exu_rd_i),
		.wbu_valid_o(wbu_valid_o),
		.wbu_ready_i(wbu_ready_i),
		.wbu_rd_o(wbu_rd_o),
		.wbu_data_o(wbu_data_o),
		.wbu_err_o(wbu_err_o)
	);

	always #20 clock = ~clock;

	// write-back scoreboard checks one result per request in order
	always @(posedge clock) begin
		if (rstn && wbu_valid_o && wbu_ready_i) begin
			results++;
			if (exp_rd_q.size() == 0) begin
				err_mon++;
				$display("write-back result arrived with no request outstanding");
			end else begin
				exp_rd = exp_rd_q.pop_front();
				exp_data = exp_data_q.pop_front();
				exp_err = exp_err_q.pop_front();
				assert (wbu_rd_o == exp_rd) else begin
					err_mon++;
					$display("Fail wbu_rd_o got %h expected %h", wbu_rd_o, exp_rd);
				end
				assert (wbu_data_o == exp_data) else begin
					err_mon++;
					$display("Fail wbu_data_o got %h expected %h", wbu_data_o, exp_data);
				end
				assert (wbu_err_o == exp_err) else begin
					err_mon++;
					$display("Fail wbu_err_o got %h expected %h", wbu_err_o, exp_err);
				end
			end
		end
	end

	always @(posedge clock) begin
		if (!rstn) begin
			in_flight <= 1'b0;
		end else if (exu_valid_i && exu_ready_o) begin
			in_flight <= 1'b1;
		end else if (wbu_valid_o && wbu_ready_i) begin
			in_flight <= 1'b0;
		end
	end

	// result held while write-back stalls
	assert property (@(posedge clock) disable iff (!rstn)
		(wbu_valid_o && !wbu_ready_i) |=> (wbu_valid_o && $stable(wbu_rd_o)
			&& $stable(wbu_data_o) && $stable(wbu_err_o)))
	else begin
		err_hold++;
		$display("Fail wbu outputs not held under back-pressure valid %h rd %h data %h err %h",
			wbu_valid_o, wbu_rd_o, wbu_data_o, wbu_err_o);
	end

	// no second request while one is in flight
	assert property (@(posedge clock) disable iff (!rstn) in_flight |-> !exu_ready_o)
	else begin
		err_busy++;
		$display("Fail exu_ready_o high with a request in flight got %h expected 0", exu_ready_o);
	end

	function automatic addr_t rand_word_addr();
		return addr_t'(`LSU_SRAM_BASE) + addr_t'(($urandom % `LSU_SRAM_WORDS) * 4);
	endfunction

	// starts 1 ns after an edge and returns 1 ns after the accepting edge
	task automatic issue(mem_op_e op, addr_t a, word_t d, reg_idx_t rd);
		int cycles;
		logic taken;
		exu_valid_i = 1'b1;
		exu_op_i = op;
		exu_addr_i = a;
		exu_wdata_i = d;
		exu_rd_i = rd;
		taken = 1'b0;
		for (cycles = 0; cycles < TIMEOUT && !taken; cycles++) begin
			@(posedge clock);
			taken = exu_ready_o;
			#1;
		end
		exu_valid_i = 1'b0;
		if (!taken) begin
			err_main++;
			$display("request was not accepted before the timeout");
		end
	endtask

	// lat is the number of edges until wbu_valid_o is first seen high
	task automatic wait_result(output int lat);
		int cycles;
		logic done;
		done = 1'b0;
		lat = 0;
		for (cycles = 1; cycles <= TIMEOUT && !done; cycles++) begin
			// ready low about a third of the time
			wbu_ready_i = (($urandom % 3) != 0);
			@(posedge clock);
			if (wbu_valid_o && lat == 0) lat = cycles;
			if (wbu_valid_o && wbu_ready_i) done = 1'b1;
			#1;
		end
		wbu_ready_i = 1'b0;
		if (!done) begin
			err_main++;
			$display("no write-back result before the timeout");
		end
	endtask

	task automatic run_request(mem_op_e op, addr_t a, word_t d, word_t exp_d, logic exp_e,
		output int lat);
		reg_idx_t rd;
		rd = reg_idx_t'($urandom);
		exp_rd_q.push_back(rd);
		exp_data_q.push_back(exp_d);
		exp_err_q.push_back(exp_e);
		requests++;
		issue(op, a, d, rd);
		wait_result(lat);
	endtask

	// in-window store merges reference bytes by lane
	task automatic store_in(mem_op_e op, addr_t a, word_t d);
		int base;
		int lat;
		base = int'(a - addr_t'(`LSU_SRAM_BASE));
		case (op)
			MEM_SB: ref_mem[base] = d[7:0];
			MEM_SH: begin
				ref_mem[base] = d[7:0];
				ref_mem[base + 1] = d[15:8];
			end
			default: begin
				for (int i = 0; i < 4; i++) ref_mem[base + i] = d[8*i +: 8];
			end
		endcase
		run_request(op, a, d, '0, 1'b0, lat);
	endtask

	// in-window load checked against the byte image
	task automatic load_in(mem_op_e op, addr_t a);
		int base;
		int lat;
		logic [15:0] half;
		word_t exp_val;
		base = int'(a - addr_t'(`LSU_SRAM_BASE));
		half = {ref_mem[base + 1], ref_mem[base]};
		case (op)
			MEM_LB: exp_val = {{24{ref_mem[base][7]}}, ref_mem[base]};
			MEM_LBU: exp_val = {24'h0, ref_mem[base]};
			MEM_LH: exp_val = {{16{half[15]}}, half};
			MEM_LHU: exp_val = {16'h0, half};
			default: exp_val = {ref_mem[base + 3], ref_mem[base + 2], half};
		endcase
		run_request(op, a, '0, exp_val, 1'b0, lat);
	endtask

	task automatic load_all_lanes(addr_t a);
		load_in(MEM_LW, a);
		for (int off = 0; off < 4; off++) begin
			load_in(MEM_LB, a + addr_t'(off));
			load_in(MEM_LBU, a + addr_t'(off));
		end
		for (int off = 0; off < 4; off += 2) begin
			load_in(MEM_LH, a + addr_t'(off));
			load_in(MEM_LHU, a + addr_t'(off));
		end
	endtask

	initial begin
		int lat;
		addr_t a;
		word_t d;
		clock = 1'b0;
		rstn = 1'b0;
		exu_valid_i = 1'b0;
		exu_op_i = MEM_NONE;
		exu_addr_i = '0;
		exu_wdata_i = '0;
		exu_rd_i = '0;
		wbu_ready_i = 1'b0;
		requests = 0;
		results = 0;
		err_main = 0;
		err_mon = 0;
		err_hold = 0;
		err_busy = 0;
		void'($urandom(SEED));
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		rstn = 1'b1;
		@(posedge clock);
		#1;

		assert (exu_ready_o == 1'b1) else begin
			err_main++;
			$display("Fail exu_ready_o after reset got %h expected 1", exu_ready_o);
		end
		assert (wbu_valid_o == 1'b0) else begin
			err_main++;
			$display("Fail wbu_valid_o after reset got %h expected 0", wbu_valid_o);
		end

		// plain ops pass the alu result with one cycle latency
		for (int i = 0; i < 10; i++) begin
			d = $urandom;
			run_request(MEM_NONE, addr_t'(d), '0, d, 1'b0, lat);
			assert (lat == 1) else begin
				err_main++;
				$display("Fail wbu_valid_o latency got %h cycles expected 1", lat);
			end
		end

		// word store then load back
		for (int i = 0; i < 8; i++) begin
			a = rand_word_addr();
			store_in(MEM_SW, a, $urandom);
			load_in(MEM_LW, a);
		end

		// byte and half merges with negative odd bytes and upper halves
		for (int w = 0; w < 4; w++) begin
			a = rand_word_addr();
			store_in(MEM_SW, a, $urandom);
			for (int off = 0; off < 4; off++) begin
				d = $urandom;
				d[7] = off[0];
				store_in(MEM_SB, a + addr_t'(off), d);
			end
			load_all_lanes(a);
			for (int off = 0; off < 4; off += 2) begin
				d = $urandom;
				d[15] = off[1];
				store_in(MEM_SH, a + addr_t'(off), d);
			end
			load_all_lanes(a);
		end

		// base plus window size would alias word 0 if the write were not dropped
		a = addr_t'(`LSU_SRAM_BASE);
		store_in(MEM_SW, a, $urandom);
		run_request(MEM_SW, a + addr_t'(WIN_BYTES), $urandom, '0, 1'b1, lat);
		run_request(MEM_SB, 32'h0000_0011, $urandom, '0, 1'b1, lat);
		run_request(MEM_LW, 32'h0000_0010, '0, '0, 1'b1, lat);
		run_request(MEM_LH, 32'h7fff_fffe, '0, '0, 1'b1, lat);
		run_request(MEM_LBU, a + addr_t'(WIN_BYTES + 3), '0, '0, 1'b1, lat);
		load_in(MEM_LW, a);

		// mixed traffic under random back-pressure
		for (int i = 0; i < 12; i++) begin
			a = rand_word_addr();
			store_in(MEM_SW, a, $urandom);
			d = $urandom;
			run_request(MEM_NONE, addr_t'(d), '0, d, 1'b0, lat);
			load_in(MEM_LH, a + 2);
		end

		@(posedge clock);
		#1;
		assert (results == requests && exp_rd_q.size() == 0) else begin
			err_main++;
			$display("Fail result count got %h expected %h", results, requests);
		end
		$display("requests %0d results %0d errors %0d", requests, results,
			err_main + err_mon + err_hold + err_busy);
		if (err_main + err_mon + err_hold + err_busy == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* lsu_top.sv */
`timescale 1ns/10ps

module lsu_top
	import lsu_pkg::*;
(
	input logic clock,
	input logic rstn,
	// request from execute
	input logic exu_valid_i,
	output logic exu_ready_o,
	input mem_op_e exu_op_i,
	// alu result, address for memory ops
	input addr_t exu_addr_i,
	input word_t exu_wdata_i,
	input reg_idx_t exu_rd_i,
	// result to write-back
	output logic wbu_valid_o,
	input logic wbu_ready_i,
	output reg_idx_t wbu_rd_o,
	output word_t wbu_data_o,
	output logic wbu_err_o
);

	// lsu to sram bus
	axi_lite_if axi_bus ();

	lsu_ctrl u_ctrl (
		.clock(clock),
		.rstn(rstn),
		.exu_valid_i(exu_valid_i),
		.exu_ready_o(exu_ready_o),
		.exu_op_i(exu_op_i),
		.exu_addr_i(exu_addr_i),
		.exu_wdata_i(exu_wdata_i),
		.exu_rd_i(exu_rd_i),
		.wbu_valid_o(wbu_valid_o),
		.wbu_ready_i(wbu_ready_i),
		.wbu_rd_o(wbu_rd_o),
		.wbu_data_o(wbu_data_o),
		.wbu_err_o(wbu_err_o),
		.axi(axi_bus)
	);

	// memory model answering the lsu
	axi_sram u_sram (
		.clock(clock),
		.rstn(rstn),
		.axi(axi_bus)
	);

endmodule

/* axi_sram.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module axi_sram
	import lsu_pkg::*;
(
	input logic clock,
	input logic rstn,
	axi_lite_if.slave axi
);

	localparam int IDX_W = $clog2(`LSU_SRAM_WORDS);
	localparam int CNT_W = $clog2(`LSU_MEM_DELAY + 1);
	localparam addr_t WIN_BYTES = addr_t'(`LSU_SRAM_WORDS * 4);

	sram_state_e state_q, state_d;
	logic [CNT_W-1:0] cnt_q;
	// pending response is a write
	logic is_wr_q;
	axi_resp_t resp_q;
	word_t rdata_q;
	word_t mem [`LSU_SRAM_WORDS];
	// offsets from window base, wrap below base makes them large
	addr_t aw_off, ar_off;
	logic aw_in_win, ar_in_win;
	logic wr_go, wr_hs, ar_hs, resp_hs;

	assign aw_off = axi.awaddr - addr_t'(`LSU_SRAM_BASE);
	assign ar_off = axi.araddr - addr_t'(`LSU_SRAM_BASE);
	assign aw_in_win = (aw_off < WIN_BYTES);
	assign ar_in_win = (ar_off < WIN_BYTES);

	// address and data are taken together, writes win over reads
	assign wr_go = axi.awvalid && axi.wvalid;
	assign axi.awready = (state_q == SRAM_IDLE) && wr_go;
	assign axi.wready = (state_q == SRAM_IDLE) && wr_go;
	assign axi.arready = (state_q == SRAM_IDLE) && !wr_go;
	assign wr_hs = axi.awready && wr_go;
	assign ar_hs = axi.arready && axi.arvalid;
	assign resp_hs = (axi.bvalid && axi.bready) || (axi.rvalid && axi.rready);

	always_comb begin
		state_d = state_q;
		case (state_q)
			SRAM_IDLE: begin
				if (wr_hs || ar_hs) begin
					if (`LSU_MEM_DELAY > 1) begin
						state_d = SRAM_WAIT;
					end else begin
						state_d = SRAM_RESP;
					end
				end
			end
			SRAM_WAIT: if (cnt_q <= 1) state_d = SRAM_RESP;
			SRAM_RESP: if (resp_hs) state_d = SRAM_IDLE;
			default: state_d = SRAM_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q <= SRAM_IDLE;
			cnt_q <= '0;
			is_wr_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (wr_hs || ar_hs) begin
				// one wait cycle is the transition into WAIT
				cnt_q <= CNT_W'(`LSU_MEM_DELAY - 1);
				is_wr_q <= wr_hs;
			end else if (state_q == SRAM_WAIT) begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	// storage and response payload
	always_ff @(posedge clock) begin
		if (wr_hs) begin
			resp_q <= aw_in_win ? AXI_OKAY : AXI_SLVERR;
			// out of window writes are dropped
			if (aw_in_win) begin
				for (int b = 0; b < $bits(strb_t); b++) begin
					if (axi.wstrb[b]) begin
						mem[aw_off[IDX_W+1:2]][8*b +: 8] <= axi.wdata[8*b +: 8];
					end
				end
			end
		end else if (ar_hs) begin
			resp_q <= ar_in_win ? AXI_OKAY : AXI_SLVERR;
			rdata_q <= ar_in_win ? mem[ar_off[IDX_W+1:2]] : '0;
		end
	end

	assign axi.bvalid = (state_q == SRAM_RESP) && is_wr_q;
	assign axi.rvalid = (state_q == SRAM_RESP) && !is_wr_q;
	assign axi.bresp = resp_q;
	assign axi.rresp = resp_q;
	assign axi.rdata = rdata_q;

endmodule

/* lsu_ctrl.sv */
`timescale 1ns/10ps

module lsu_ctrl
	import lsu_pkg::*;
(
	input logic clock,
	input logic rstn,
	// execute side
	input logic exu_valid_i,
	output logic exu_ready_o,
	input mem_op_e exu_op_i,
	input addr_t exu_addr_i,
	input word_t exu_wdata_i,
	input reg_idx_t exu_rd_i,
	// write-back side
	output logic wbu_valid_o,
	input logic wbu_ready_i,
	output reg_idx_t wbu_rd_o,
	output word_t wbu_data_o,
	output logic wbu_err_o,
	// memory port
	axi_lite_if.master axi
);

	lsu_state_e state_q, state_d;
	// request captured at accept
	mem_op_e op_q;
	addr_t addr_q;
	word_t wdata_q;
	reg_idx_t rd_q;
	// result for write-back
	word_t res_data_q;
	logic res_err_q;
	// address phases already taken
	logic aw_done_q, w_done_q, ar_done_q;
	word_t load_data;
	logic accept, aw_hs, w_hs, b_hs, ar_hs, r_hs, wb_hs;

	function automatic logic op_is_store(mem_op_e op);
		return op inside {MEM_SB, MEM_SH, MEM_SW};
	endfunction

	function automatic logic op_is_load(mem_op_e op);
		return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
	endfunction

	// channel transfers
	assign accept = exu_valid_i && exu_ready_o;
	assign aw_hs = axi.awvalid && axi.awready;
	assign w_hs = axi.wvalid && axi.wready;
	assign b_hs = axi.bvalid && axi.bready;
	assign ar_hs = axi.arvalid && axi.arready;
	assign r_hs = axi.rvalid && axi.rready;
	assign wb_hs = wbu_valid_o && wbu_ready_i;

	// lane shifting, strobes and load extension
	lsu_align u_align (
		.op_i(op_q),
		.offset_i(addr_q[1:0]),
		.store_data_i(wdata_q),
		.load_word_i(axi.rdata),
		.strb_o(axi.wstrb),
		.store_word_o(axi.wdata),
		.load_data_o(load_data)
	);

	// one request in flight, choose path at accept
	always_comb begin
		state_d = state_q;
		case (state_q)
			LSU_IDLE: begin
				if (accept) begin
					if (op_is_store(exu_op_i)) begin
						state_d = LSU_WRITE;
					end else if (op_is_load(exu_op_i)) begin
						state_d = LSU_READ;
					end else begin
						state_d = LSU_DONE;
					end
				end
			end
			LSU_WRITE: if (b_hs) state_d = LSU_DONE;
			LSU_READ: if (r_hs) state_d = LSU_DONE;
			LSU_DONE: if (wb_hs) state_d = LSU_IDLE;
			default: state_d = LSU_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q <= LSU_IDLE;
			aw_done_q <= 1'b0;
			w_done_q <= 1'b0;
			ar_done_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (accept) begin
				aw_done_q <= 1'b0;
				w_done_q <= 1'b0;
				ar_done_q <= 1'b0;
			end else begin
				// aw and w may be taken in different cycles
				if (aw_hs) aw_done_q <= 1'b1;
				if (w_hs) w_done_q <= 1'b1;
				if (ar_hs) ar_done_q <= 1'b1;
			end
		end
	end

	// request payload
	always_ff @(posedge clock) begin
		if (accept) begin
			op_q <= exu_op_i;
			addr_q <= exu_addr_i;
			wdata_q <= exu_wdata_i;
			rd_q <= exu_rd_i;
		end
	end

	// plain ops keep the alu result, memory ops overwrite on response
	always_ff @(posedge clock) begin
		if (accept) begin
			res_data_q <= exu_addr_i;
			res_err_q <= 1'b0;
		end else if (b_hs) begin
			res_data_q <= '0;
			res_err_q <= (axi.bresp != AXI_OKAY);
		end else if (r_hs) begin
			// error reads give zero data
			res_data_q <= (axi.rresp == AXI_OKAY) ? load_data : '0;
			res_err_q <= (axi.rresp != AXI_OKAY);
		end
	end

	// bus address is word aligned, strobe picks the bytes
	assign axi.awaddr = {addr_q[$bits(addr_t)-1:2], 2'b00};
	assign axi.araddr = {addr_q[$bits(addr_t)-1:2], 2'b00};
	assign axi.awvalid = (state_q == LSU_WRITE) && !aw_done_q;
	assign axi.wvalid = (state_q == LSU_WRITE) && !w_done_q;
	assign axi.bready = (state_q == LSU_WRITE) && aw_done_q && w_done_q;
	assign axi.arvalid = (state_q == LSU_READ) && !ar_done_q;
	assign axi.rready = (state_q == LSU_READ);

	assign exu_ready_o = (state_q == LSU_IDLE);
	assign wbu_valid_o = (state_q == LSU_DONE);
	assign wbu_rd_o = rd_q;
	assign wbu_data_o = res_data_q;
	assign wbu_err_o = res_err_q;

endmodule

/* lsu_align.sv */
`timescale 1ns/10ps

module lsu_align
	import lsu_pkg::*;
(
	input mem_op_e op_i,
	input logic [1:0] offset_i,
	input word_t store_data_i,
	input word_t load_word_i,
	output strb_t strb_o,
	output word_t store_word_o,
	output word_t load_data_o
);

	// byte offset as a bit shift amount
	logic [4:0] shamt;
	// returned word moved down to lane 0
	word_t load_shifted;

	assign shamt = {offset_i, 3'b000};
	assign load_shifted = load_word_i >> shamt;

	// store side, data moves up into its lane
	always_comb begin
		strb_o = '0;
		store_word_o = store_data_i;
		case (op_i)
			MEM_SB: begin
				strb_o = strb_t'(4'b0001) << offset_i;
				store_word_o = store_data_i << shamt;
			end
			MEM_SH: begin
				// halves sit at offset 0 or 2 only
				strb_o = strb_t'(4'b0011) << {offset_i[1], 1'b0};
				store_word_o = store_data_i << {offset_i[1], 4'b0000};
			end
			MEM_SW: begin
				strb_o = '1;
			end
			default: begin
				// no byte lanes for loads or plain ops
				strb_o = '0;
			end
		endcase
	end

	// load side, pick lane 0 then extend
	always_comb begin
		case (op_i)
			MEM_LB: load_data_o = word_t'($signed(load_shifted[7:0]));
			MEM_LH: load_data_o = word_t'($signed(load_shifted[15:0]));
			MEM_LBU: load_data_o = word_t'(load_shifted[7:0]);
			MEM_LHU: load_data_o = word_t'(load_shifted[15:0]);
			// lw is word aligned, shift is zero
			default: load_data_o = load_shifted;
		endcase
	end

endmodule

/* axi_lite_if.sv */
`timescale 1ns/10ps

interface axi_lite_if
	import lsu_pkg::*;
();

	// write address channel
	addr_t awaddr;
	logic awvalid;
	logic awready;

	// write data channel
	word_t wdata;
	strb_t wstrb;
	logic wvalid;
	logic wready;

	// write response channel
	axi_resp_t bresp;
	logic bvalid;
	logic bready;

	// read address channel
	addr_t araddr;
	logic arvalid;
	logic arready;

	// read data channel
	word_t rdata;
	axi_resp_t rresp;
	logic rvalid;
	logic rready;

	// lsu side
	modport master (
		output awaddr, awvalid, input awready,
		output wdata, wstrb, wvalid, input wready,
		input bresp, bvalid, output bready,
		output araddr, arvalid, input arready,
		input rdata, rresp, rvalid, output rready
	);

	// memory side
	modport slave (
		input awaddr, awvalid, output awready,
		input wdata, wstrb, wvalid, output wready,
		output bresp, bvalid, input bready,
		input araddr, arvalid, output arready,
		output rdata, rresp, rvalid, input rready
	);

endinterface

/* lsu_pkg.sv */
`include "lsu_config.svh"

package lsu_pkg;

	// payload widths
	typedef logic [`LSU_DATA_W-1:0] word_t;
	typedef logic [`LSU_DATA_W-1:0] addr_t;
	// one strobe bit per byte lane
	typedef logic [`LSU_DATA_W/8-1:0] strb_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [1:0] axi_resp_t;

	// axi response codes in use
	localparam axi_resp_t AXI_OKAY = 2'b00;
	localparam axi_resp_t AXI_SLVERR = 2'b10;

	// operation from execute stage
	typedef enum logic [3:0] {
		MEM_NONE = 4'd0,
		MEM_LB = 4'd1,
		MEM_LH = 4'd2,
		MEM_LW = 4'd3,
		MEM_LBU = 4'd4,
		MEM_LHU = 4'd5,
		MEM_SB = 4'd6,
		MEM_SH = 4'd7,
		MEM_SW = 4'd8
	} mem_op_e;

	// controller fsm
	typedef enum logic [1:0] {LSU_IDLE, LSU_WRITE, LSU_READ, LSU_DONE} lsu_state_e;

	// sram fsm
	typedef enum logic [1:0] {SRAM_IDLE, SRAM_WAIT, SRAM_RESP} sram_state_e;

endpackage

/* lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data path and address width in bits
`define LSU_DATA_W 32

// first byte address of the sram window
`define LSU_SRAM_BASE 32'h8000_0000

// sram depth in words
`define LSU_SRAM_WORDS 256

// cycles from address accept to response
// values below 2 fall back to the shortest response path
`define LSU_MEM_DELAY 2

`endif
